// File: memPkg.sv
package memPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data path width in bits
  localparam int DATA_W = 32;

  // Byte lanes in one word
  localparam int BYTES_PER_WORD = 4;

  // Default data memory depth in words
  localparam int DEFAULT_DEPTH = 256;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // One data word, also used for byte addresses
  typedef logic [DATA_W-1:0] dataT;

  // Byte n enables data bits 8n+7..8n
  typedef logic [BYTES_PER_WORD-1:0] byteEnT;

  // Destination register index for writeback
  typedef logic [4:0] regIdxT;

  // Memory opcode handed over by the execute stage
  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LW,
    MEM_LH,
    MEM_LHU,
    MEM_LB,
    MEM_LBU,
    MEM_SW,
    MEM_SH,
    MEM_SB
  } memOpT;

  // Access width, word first
  typedef enum logic [1:0] {
    WIDTH_WORD = 2'b00,
    WIDTH_HALF = 2'b01,
    WIDTH_BYTE = 2'b10
  } accessWidthT;

endpackage

// File: memIfs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// EX/MEM request as seen by the MEM stage
////////////////////////////////////////////////////////////

interface memAccessIf;
  // Access strobes, never both high
  logic                memRead;
  logic                memWrite;
  // Access shape
  memPkg::accessWidthT width;
  logic                loadUnsigned;
  // Operands
  memPkg::dataT        addr;
  memPkg::dataT        storeData;
  memPkg::regIdxT      regIdx;

  // Pipeline register side
  modport stage (output memRead, memWrite, width, loadUnsigned, addr, storeData, regIdx);
  // Store lane placement
  modport store (input memWrite, width, addr, storeData);
  // Load extraction and MEM/WB register
  modport load (input memRead, width, loadUnsigned, addr, regIdx);
endinterface

////////////////////////////////////////////////////////////
// Data memory port
////////////////////////////////////////////////////////////

interface memPortIf;
  // Write side, already lane aligned
  logic           wrEn;
  memPkg::byteEnT byteEn;
  memPkg::dataT   addr;
  memPkg::dataT   wrData;
  // Whole word read back
  memPkg::dataT   rdData;

  modport requester (output wrEn, byteEn, addr, wrData);
  modport memory (input wrEn, byteEn, addr, wrData, output rdData);
  modport reader (input rdData);
endinterface

// File: memRequestStage.sv
`timescale 1ns/1ps

module memRequestStage (
  input  logic           clk,
  input  logic           rstN,
  input  memPkg::memOpT  op,
  input  memPkg::dataT   addr,
  input  memPkg::dataT   storeData,
  input  memPkg::regIdxT regIdx,
  memAccessIf.stage      req
);

  // Decoded controls, EX side
  logic                isRead;
  logic                isWrite;
  logic                isUnsigned;
  memPkg::accessWidthT decWidth;

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // MEM_NONE and unknown codes do nothing
    isRead     = 1'b0;
    isWrite    = 1'b0;
    isUnsigned = 1'b0;
    decWidth   = memPkg::WIDTH_WORD;
    case (op)
      memPkg::MEM_LW: isRead = 1'b1;
      memPkg::MEM_LH: begin
        isRead   = 1'b1;
        decWidth = memPkg::WIDTH_HALF;
      end
      memPkg::MEM_LHU: begin
        isRead     = 1'b1;
        isUnsigned = 1'b1;
        decWidth   = memPkg::WIDTH_HALF;
      end
      memPkg::MEM_LB: begin
        isRead   = 1'b1;
        decWidth = memPkg::WIDTH_BYTE;
      end
      memPkg::MEM_LBU: begin
        isRead     = 1'b1;
        isUnsigned = 1'b1;
        decWidth   = memPkg::WIDTH_BYTE;
      end
      memPkg::MEM_SW: isWrite = 1'b1;
      memPkg::MEM_SH: begin
        isWrite  = 1'b1;
        decWidth = memPkg::WIDTH_HALF;
      end
      memPkg::MEM_SB: begin
        isWrite  = 1'b1;
        decWidth = memPkg::WIDTH_BYTE;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////

  // Strobes, cleared on reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      req.memRead  <= 1'b0;
      req.memWrite <= 1'b0;
    end else begin
      req.memRead  <= isRead;
      req.memWrite <= isWrite;
    end
  end

  // Payload follows the strobes
  always_ff @(posedge clk) begin
    req.width        <= decWidth;
    req.loadUnsigned <= isUnsigned;
    req.addr         <= addr;
    req.storeData    <= storeData;
    req.regIdx       <= regIdx;
  end

endmodule

// File: storeAlign.sv
`timescale 1ns/1ps

module storeAlign (
  memAccessIf.store   req,
  memPortIf.requester port
);

  // Byte offset inside the addressed word
  logic [1:0]      lane;
  memPkg::dataT    laneData;
  memPkg::byteEnT  laneEn;

  assign lane = req.addr[1:0];

  ////////////////////////////////////////////////////////////
  // Lane placement and byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Unused lanes carry zero
    laneData = '0;
    laneEn   = '0;
    case (req.width)
      memPkg::WIDTH_WORD: begin
        // Whole word, offset ignored
        laneData = req.storeData;
        laneEn   = 4'b1111;
      end
      memPkg::WIDTH_HALF: begin
        // Bit 1 picks the half, bit 0 ignored
        if (lane[1]) begin
          laneData = {req.storeData[15:0], 16'b0};
          laneEn   = 4'b1100;
        end else begin
          laneData = {16'b0, req.storeData[15:0]};
          laneEn   = 4'b0011;
        end
      end
      memPkg::WIDTH_BYTE: begin
        // Low byte moved up by 8 bits per lane
        laneData = memPkg::dataT'(req.storeData[7:0]) << {lane, 3'b000};
        laneEn   = memPkg::byteEnT'(4'b0001 << lane);
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Memory port
  ////////////////////////////////////////////////////////////

  // Only stores write
  assign port.wrEn   = req.memWrite;
  assign port.byteEn = laneEn;
  assign port.wrData = laneData;
  // Same address serves the read path
  assign port.addr   = req.addr;

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
  parameter int depth = memPkg::DEFAULT_DEPTH
) (
  input  logic     clk,
  memPortIf.memory port
);

  // Word index width, at least one bit
  localparam int idxW  = (depth > 1) ? $clog2(depth) : 1;
  // Byte offset bits below the word index
  localparam int laneW = $clog2(memPkg::BYTES_PER_WORD);

  // Word array, contents survive reset
  memPkg::dataT   mem [depth];
  logic [idxW-1:0] wordIdx;

  // Word address wraps at depth
  assign wordIdx = idxW'(port.addr[memPkg::DATA_W-1:laneW] % depth);

  ////////////////////////////////////////////////////////////
  // Byte masked write
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (port.wrEn) begin
      for (int b = 0; b < memPkg::BYTES_PER_WORD; b++) begin
        // Untouched lanes keep their old byte
        if (port.byteEn[b]) begin
          mem[wordIdx][b*8 +: 8] <= port.wrData[b*8 +: 8];
        end
      end
    end
  end

  // Asynchronous read of the whole word
  assign port.rdData = mem[wordIdx];

endmodule

// File: loadUnit.sv
`timescale 1ns/1ps

module loadUnit (
  input  logic           clk,
  input  logic           rstN,
  memAccessIf.load       req,
  memPortIf.reader       port,
  output logic           loadValid,
  output memPkg::dataT   loadData,
  output memPkg::regIdxT loadReg
);

  // Byte offset inside the word
  logic [1:0]   lane;
  // Selected slices before extension
  logic [15:0]  halfSel;
  logic [7:0]   byteSel;
  memPkg::dataT extData;

  assign lane = req.addr[1:0];

  ////////////////////////////////////////////////////////////
  // Lane extraction
  ////////////////////////////////////////////////////////////

  // Half from bit 1 only, bit 0 ignored
  assign halfSel = lane[1] ? port.rdData[31:16] : port.rdData[15:0];
  // Byte from any of the four lanes
  assign byteSel = port.rdData[{lane, 3'b000} +: 8];

  ////////////////////////////////////////////////////////////
  // Sign or zero extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    extData = port.rdData;
    case (req.width)
      memPkg::WIDTH_HALF: begin
        if (req.loadUnsigned) begin
          extData = {16'b0, halfSel};
        end else begin
          extData = {{16{halfSel[15]}}, halfSel};
        end
      end
      memPkg::WIDTH_BYTE: begin
        if (req.loadUnsigned) begin
          extData = {24'b0, byteSel};
        end else begin
          extData = {{24{byteSel[7]}}, byteSel};
        end
      end
      // Word passes through unchanged
      default: extData = port.rdData;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////

  // Valid only for loads
  always_ff @(posedge clk) begin
    if (!rstN) begin
      loadValid <= 1'b0;
    end else begin
      loadValid <= req.memRead;
    end
  end

  // Loaded word and its destination
  always_ff @(posedge clk) begin
    loadData <= extData;
    loadReg  <= req.regIdx;
  end

endmodule

// File: memAccessTop.sv
`timescale 1ns/1ps

module memAccessTop #(
  parameter int memDepth = memPkg::DEFAULT_DEPTH
) (
  input  logic           clk,
  input  logic           rstN,
  // Request from the execute stage
  input  memPkg::memOpT  op,
  input  memPkg::dataT   addr,
  input  memPkg::dataT   storeData,
  input  memPkg::regIdxT regIdx,
  // Result toward writeback
  output logic           loadValid,
  output memPkg::dataT   loadData,
  output memPkg::regIdxT loadReg
);

  ////////////////////////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////////////////////////

  // Registered MEM stage request
  memAccessIf reqIf ();
  // Data memory port
  memPortIf   memPort ();

  // EX/MEM register and opcode decode
  memRequestStage reqStage (
    .clk       (clk),
    .rstN      (rstN),
    .op        (op),
    .addr      (addr),
    .storeData (storeData),
    .regIdx    (regIdx),
    .req       (reqIf.stage)
  );

  // Store lanes and byte enables
  storeAlign storeLanes (
    .req  (reqIf.store),
    .port (memPort.requester)
  );

  // Word RAM, depth set from the top
  dataMemory #(
    .depth (memDepth)
  ) dataMem (
    .clk  (clk),
    .port (memPort.memory)
  );

  // Load extraction and MEM/WB register
  loadUnit loadPath (
    .clk       (clk),
    .rstN      (rstN),
    .req       (reqIf.load),
    .port      (memPort.reader),
    .loadValid (loadValid),
    .loadData  (loadData),
    .loadReg   (loadReg)
  );

endmodule

// File: tb_memAccess.sv
`timescale 1ns/1ps

module tb_memAccess;

  localparam int CLK_PERIOD    = 10;
  localparam int MODEL_DEPTH   = 16;
  localparam int RESET_CYCLES  = 5;
  localparam int PARTIAL_PAIRS = 40;
  localparam int EXT_ROUNDS    = 8;
  localparam int STREAM_LEN    = 400;
  localparam int DRAIN_CYCLES  = 5;
  // Issued cycles of all tests plus a margin
  localparam int RUN_CYCLES = RESET_CYCLES + 2 * MODEL_DEPTH + 2 * PARTIAL_PAIRS
                            + EXT_ROUNDS * 17 + STREAM_LEN + DRAIN_CYCLES + 1;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 50;

  logic           clk;
  logic           rstN;
  memPkg::memOpT  op;
  memPkg::dataT   addr;
  memPkg::dataT   storeData;
  memPkg::regIdxT regIdx;
  logic           loadValid;
  memPkg::dataT   loadData;
  memPkg::regIdxT loadReg;

  // Reference memory and expected results in issue order
  memPkg::dataT   model [MODEL_DEPTH];
  int             dueQ [$];
  memPkg::dataT   dataQ [$];
  memPkg::regIdxT regQ [$];
  int             edgeCnt;
  logic [31:0]    lcgState;

  memAccessTop #(
    .memDepth (MODEL_DEPTH)
  ) u_memAccessTop (
    .clk       (clk),
    .rstN      (rstN),
    .op        (op),
    .addr      (addr),
    .storeData (storeData),
    .regIdx    (regIdx),
    .loadValid (loadValid),
    .loadData  (loadData),
    .loadReg   (loadReg)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Counts rising edges, read before its own update at each edge
  always @(posedge clk) edgeCnt <= edgeCnt + 1;

  ////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    // Upper state bits folded into the short-period low bits
    return lcgState ^ (lcgState >> 16);
  endfunction

  // Word index wraps at the memory depth
  function automatic int wordOf(memPkg::dataT a);
    return (a >> 2) % MODEL_DEPTH;
  endfunction

  function automatic void applyStore(memPkg::memOpT o, memPkg::dataT a, memPkg::dataT d);
    int w;
    int lane;
    w    = wordOf(a);
    lane = {30'b0, a[1:0]};
    case (o)
      memPkg::MEM_SW: model[w] = d;
      // Halfword aligned down, bit 0 of the address ignored
      memPkg::MEM_SH: model[w][16 * (lane / 2) +: 16] = d[15:0];
      memPkg::MEM_SB: model[w][8 * lane +: 8] = d[7:0];
      default: ;
    endcase
  endfunction

  function automatic memPkg::dataT expectLoad(memPkg::memOpT o, memPkg::dataT a);
    memPkg::dataT w;
    logic [15:0]  h;
    logic [7:0]   b;
    int           lane;
    w    = model[wordOf(a)];
    lane = {30'b0, a[1:0]};
    h    = w[16 * (lane / 2) +: 16];
    b    = w[8 * lane +: 8];
    case (o)
      memPkg::MEM_LH:  return {{16{h[15]}}, h};
      memPkg::MEM_LHU: return {16'b0, h};
      memPkg::MEM_LB:  return {{24{b[7]}}, b};
      memPkg::MEM_LBU: return {24'b0, b};
      default:         return w;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stopRun();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkData(memPkg::dataT got, memPkg::dataT exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkReg(memPkg::regIdxT got, memPkg::regIdxT exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkValid(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
      stopRun();
    end
  endtask

  // One request per edge, model updated at issue
  task automatic issue(memPkg::memOpT o, memPkg::dataT a, memPkg::dataT d, memPkg::regIdxT r);
    @(posedge clk);
    op        <= o;
    addr      <= a;
    storeData <= d;
    regIdx    <= r;
    if (o inside {memPkg::MEM_LW, memPkg::MEM_LH, memPkg::MEM_LHU,
                  memPkg::MEM_LB, memPkg::MEM_LBU}) begin
      // Sampled at the next edge, result visible two edges later
      dueQ.push_back(edgeCnt + 3);
      dataQ.push_back(expectLoad(o, a));
      regQ.push_back(r);
    end else begin
      applyStore(o, a, d);
    end
  endtask

  // Output checked every cycle away from the clock edge
  initial begin
    forever begin
      @(negedge clk);
      if (dueQ.size() > 0 && dueQ[0] == edgeCnt) begin
        checkValid(loadValid, 1'b1, "loadValid");
        checkData(loadData, dataQ[0], "loadData");
        checkReg(loadReg, regQ[0], "loadReg");
        void'(dueQ.pop_front());
        void'(dataQ.pop_front());
        void'(regQ.pop_front());
      end else begin
        checkValid(loadValid, 1'b0, "loadValid");
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stopRun();
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]    r;
    logic [3:0]     opCode;
    memPkg::dataT   base;
    memPkg::memOpT  stOp;
    lcgState  = 32'hd4ae_57c6;
    rstN      = 1'b0;
    op        = memPkg::MEM_NONE;
    addr      = '0;
    storeData = '0;
    regIdx    = '0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(posedge clk);
    rstN <= 1'b1;

    // Fill every word, then read each back
    for (int i = 0; i < MODEL_DEPTH; i++) issue(memPkg::MEM_SW, i * 4, nextRand(), '0);
    for (int i = 0; i < MODEL_DEPTH; i++) issue(memPkg::MEM_LW, i * 4, '0, 5'(i));

    // Partial store, then word load in the very next cycle
    for (int n = 0; n < PARTIAL_PAIRS; n++) begin
      r    = nextRand();
      stOp = r[0] ? memPkg::MEM_SH : memPkg::MEM_SB;
      base = nextRand();
      issue(stOp, base, nextRand(), '0);
      issue(memPkg::MEM_LW, base, '0, 5'(n));
    end

    // Sign and zero extension at all four offsets
    for (int k = 0; k < EXT_ROUNDS; k++) begin
      r    = nextRand();
      base = {r[31:2], 2'b00};
      r    = nextRand();
      // Alternate rounds set or clear every lane's top bit
      r    = k[0] ? (r & 32'h7f7f_7f7f) : (r | 32'h8080_8080);
      issue(memPkg::MEM_SW, base, r, '0);
      for (int off = 0; off < 4; off++) begin
        issue(memPkg::MEM_LB, base | off, '0, 5'(off));
        issue(memPkg::MEM_LBU, base | off, '0, 5'(off + 4));
        issue(memPkg::MEM_LH, base | off, '0, 5'(off + 8));
        issue(memPkg::MEM_LHU, base | off, '0, 5'(off + 12));
      end
    end

    // Long mixed stream of all nine opcodes
    for (int n = 0; n < STREAM_LEN; n++) begin
      r      = nextRand();
      opCode = 4'(r % 9);
      r      = nextRand();
      issue(memPkg::memOpT'(opCode), nextRand(), nextRand(), r[4:0]);
    end

    repeat (DRAIN_CYCLES) issue(memPkg::MEM_NONE, '0, '0, '0);
    @(posedge clk);
    if (dueQ.size() != 0) begin
      $display("error: %0d loads never produced a result", dueQ.size());
      stopRun();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: flist.f
memPkg.sv
memIfs.sv
memRequestStage.sv
storeAlign.sv
dataMemory.sv
loadUnit.sv
memAccessTop.sv
tb_memAccess.sv

// File: Makefile
# Verilator build for the memory access stage

VERILATOR ?= verilator
TOP       ?= tb_memAccess
RTL_TOP   ?= memAccessTop
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status of the simulation decides pass or fail
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
